//--- vlog.f
cache_pkg.sv
icache.sv
dcache.sv
mem_port_arbiter.sv
cache_subsystem.sv
tb_cache_subsystem_chk.sv
tb_cache_subsystem.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_cache_subsystem -o sim || exit 1
out="$(./obj_dir/sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '** PASS **' && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- tb_cache_subsystem.sv
// Cache subsystem testbench
`timescale 1ns/1ps

module tb_cache_subsystem;

    localparam int               NUM_TESTS = 5;
    localparam cache_pkg::data_t FILL_KEY  = 32'h5a5a_c3c3;

    logic               clk_i;
    logic               rst_n_i         = 1'b0;
    logic               icache_en_i     = 1'b1;
    logic               icache_flush_i  = 1'b0;
    logic               fetch_req_i     = 1'b0;
    cache_pkg::addr_t   fetch_addr_i    = '0;
    logic               fetch_valid_o;
    cache_pkg::data_t   fetch_data_o;
    logic               icache_miss_o;
    logic               dcache_enable_i = 1'b1;
    logic               dcache_flush_i  = 1'b0;
    logic               dcache_flush_ack_o;
    logic               dreq_i          = 1'b0;
    logic               dwe_i           = 1'b0;
    cache_pkg::addr_t   daddr_i         = '0;
    cache_pkg::data_t   dwdata_i        = '0;
    logic               dack_o;
    cache_pkg::data_t   drdata_o;
    logic               dcache_miss_o;
    logic               mem_req_valid_o;
    logic               mem_req_ready_i = 1'b0;
    logic               mem_req_we_o;
    cache_pkg::addr_t   mem_req_addr_o;
    cache_pkg::data_t   mem_req_wdata_o;
    cache_pkg::mem_id_t mem_req_id_o;
    logic               mem_rsp_valid_i = 1'b0;
    cache_pkg::mem_id_t mem_rsp_id_i    = '0;
    cache_pkg::data_t   mem_rsp_rdata_i = '0;

    int errors;
    int ic_miss_cnt;
    int dc_miss_cnt;

    cache_subsystem cache_subsystem_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------------
    // memory model
    // ------------------------------------------------------------------------
    logic [31:0]        rnd = 32'h641f_4dfa;
    cache_pkg::data_t   mem_q [cache_pkg::addr_t];   // written words only
    cache_pkg::mem_id_t rsp_id_q [$];
    cache_pkg::data_t   rsp_data_q [$];
    int                 rsp_due_q [$];
    cache_pkg::mem_id_t accepted_id_q [$];
    int                 req_cnt [2];
    int                 cycle_cnt;
    int                 last_due;
    int                 due;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cache_pkg::data_t mem_word(input cache_pkg::addr_t addr);
        if (mem_q.exists(addr)) return mem_q[addr];
        return addr ^ FILL_KEY;   // untouched words follow the address
    endfunction

    always @(posedge clk_i) begin
        rnd = lcg_next(rnd);
        cycle_cnt++;
        mem_req_ready_i <= (rnd[23:22] != 2'b00);   // low about one cycle in four
        mem_rsp_valid_i <= 1'b0;
        if (!rst_n_i) begin
            rsp_id_q.delete();
            rsp_data_q.delete();
            rsp_due_q.delete();
            last_due = cycle_cnt;
        end else begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                req_cnt[mem_req_id_o]++;
                accepted_id_q.push_back(mem_req_id_o);
                due = cycle_cnt + 1 + int'(rnd[17:16]);
                if (due <= last_due) due = last_due + 1;   // answers stay in order
                last_due = due;
                if (mem_req_we_o) mem_q[mem_req_addr_o] = mem_req_wdata_o;
                rsp_id_q.push_back(mem_req_id_o);
                rsp_data_q.push_back(mem_req_we_o ? '0 : mem_word(mem_req_addr_o));
                rsp_due_q.push_back(due);
            end
            if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_cnt) begin
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_id_i    <= rsp_id_q.pop_front();
                mem_rsp_rdata_i <= rsp_data_q.pop_front();
                void'(rsp_due_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        if (icache_miss_o) ic_miss_cnt++;
        if (dcache_miss_o) dc_miss_cnt++;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst_n_i <= 1'b0;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
    endtask

    // lat counts cycles from the strobe edge to the edge that sees the pulse
    task automatic fetch(input cache_pkg::addr_t addr, output cache_pkg::data_t data,
                         output int lat);
        fetch_addr_i <= addr;
        fetch_req_i  <= 1'b1;
        @(posedge clk_i);
        fetch_req_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (!fetch_valid_o);
        data = fetch_data_o;
    endtask

    task automatic access(input logic we, input cache_pkg::addr_t addr,
                          input cache_pkg::data_t wdata, output cache_pkg::data_t data,
                          output int lat);
        dwe_i    <= we;
        daddr_i  <= addr;
        dwdata_i <= wdata;
        dreq_i   <= 1'b1;
        @(posedge clk_i);
        dreq_i <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (!dack_o);
        data = drdata_o;
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_icache_hit();
        cache_pkg::addr_t addr = 32'h0000_1004;
        cache_pkg::data_t data;
        int lat;
        int misses;
        int reqs;
        misses = ic_miss_cnt;
        reqs   = req_cnt[cache_pkg::ID_ICACHE];
        fetch(addr, data, lat);
        check("fetch_data_o", data, mem_word(addr));
        fetch(addr, data, lat);
        check("fetch_data_o", data, mem_word(addr));
        check("fetch hit latency", lat, 1);
        check("icache_miss_o count", ic_miss_cnt - misses, 1);
        check("icache requests", req_cnt[cache_pkg::ID_ICACHE] - reqs, 1);
    endtask

    task automatic test_icache_flush();
        cache_pkg::addr_t addr = 32'h0000_2008;
        cache_pkg::data_t data;
        int lat;
        int misses;
        int reqs;
        fetch(addr, data, lat);
        fetch(addr, data, lat);   // line now valid
        icache_flush_i <= 1'b1;
        @(posedge clk_i);
        icache_flush_i <= 1'b0;
        misses = ic_miss_cnt;
        fetch(addr, data, lat);
        check("icache_miss_o after flush", ic_miss_cnt - misses, 1);
        check("fetch_data_o", data, mem_word(addr));
        icache_en_i <= 1'b0;
        reqs = req_cnt[cache_pkg::ID_ICACHE];
        repeat (2) begin
            fetch(addr + 4, data, lat);
            check("fetch_data_o bypass", data, mem_word(addr + 4));
        end
        check("icache bypass requests", req_cnt[cache_pkg::ID_ICACHE] - reqs, 2);
        icache_en_i <= 1'b1;
        misses = ic_miss_cnt;
        fetch(addr + 4, data, lat);
        check("icache_miss_o after bypass", ic_miss_cnt - misses, 1);   // bypass left no line
    endtask

    task automatic test_dcache_write();
        cache_pkg::addr_t addr = 32'h0000_8010;
        cache_pkg::data_t data;
        int lat;
        int misses;
        int reqs;
        misses = dc_miss_cnt;
        access(1'b1, addr, 32'hcafe_0001, data, lat);
        check("memory word after write", mem_word(addr), 32'hcafe_0001);
        check("dcache_miss_o on write", dc_miss_cnt - misses, 0);
        access(1'b0, addr, '0, data, lat);
        check("dcache_miss_o on read", dc_miss_cnt - misses, 1);   // write miss left no line
        check("drdata_o", data, 32'hcafe_0001);
        access(1'b1, addr, 32'hcafe_0002, data, lat);
        check("memory word after write hit", mem_word(addr), 32'hcafe_0002);
        reqs = req_cnt[cache_pkg::ID_DCACHE];
        access(1'b0, addr, '0, data, lat);
        check("drdata_o after write hit", data, 32'hcafe_0002);
        check("read hit latency", lat, 1);
        check("dcache requests on hit", req_cnt[cache_pkg::ID_DCACHE] - reqs, 0);
    endtask

    task automatic test_dcache_flush();
        cache_pkg::addr_t addr = 32'h0000_9014;
        cache_pkg::data_t data;
        int lat;
        int misses;
        int reqs;
        access(1'b0, addr, '0, data, lat);
        access(1'b0, addr, '0, data, lat);
        check("read hit latency", lat, 1);
        dcache_flush_i <= 1'b1;
        @(posedge clk_i);
        lat = 0;
        do begin
            @(posedge clk_i);
            lat++;
        end while (!dcache_flush_ack_o);
        dcache_flush_i <= 1'b0;
        check("dcache_flush_ack_o latency", lat, 1);
        @(posedge clk_i);   // FSM leaves FLUSH once the level drops
        misses = dc_miss_cnt;
        access(1'b0, addr, '0, data, lat);
        check("dcache_miss_o after flush", dc_miss_cnt - misses, 1);
        check("drdata_o", data, mem_word(addr));
        dcache_enable_i <= 1'b0;
        reqs = req_cnt[cache_pkg::ID_DCACHE];
        repeat (3) begin
            access(1'b0, addr, '0, data, lat);
            check("drdata_o bypass", data, mem_word(addr));
        end
        check("dcache bypass requests", req_cnt[cache_pkg::ID_DCACHE] - reqs, 3);
        dcache_enable_i <= 1'b1;
    endtask

    task automatic test_concurrent_miss();
        cache_pkg::addr_t iaddr = 32'h0000_3000;
        cache_pkg::addr_t daddr = 32'h0000_a008;
        cache_pkg::data_t idata;
        cache_pkg::data_t ddata;
        int ilat;
        int dlat;
        int first;
        apply_reset();   // arbiter back to its reset priority
        first = accepted_id_q.size();
        fork
            fetch(iaddr, idata, ilat);
            access(1'b0, daddr, '0, ddata, dlat);
        join
        check("fetch_data_o", idata, mem_word(iaddr));
        check("drdata_o", ddata, mem_word(daddr));
        check("first mem_req_id_o", 32'(accepted_id_q[first]), 32'(cache_pkg::ID_ICACHE));
    endtask

    initial begin
        apply_reset();
        test_icache_hit();
        test_icache_flush();
        test_dcache_write();
        test_dcache_flush();
        test_concurrent_miss();
        $display("tests: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk_i);
        $display("timeout: tests still running after %0d cycles", NUM_TESTS * 200);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- tb_cache_subsystem_chk.sv
// Memory port and pulse assertions
`timescale 1ns/1ps

module cache_subsystem_chk (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               mem_req_valid_o,
    input logic               mem_req_ready_i,
    input logic               mem_req_we_o,
    input cache_pkg::addr_t   mem_req_addr_o,
    input cache_pkg::data_t   mem_req_wdata_o,
    input cache_pkg::mem_id_t mem_req_id_o,
    input logic               dcache_flush_ack_o,
    input logic               fetch_valid_o,
    input logic               dack_o
);

    // request holds until the handshake
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
        && $stable(mem_req_we_o) && $stable(mem_req_addr_o)
        && $stable(mem_req_wdata_o) && $stable(mem_req_id_o))
        else $error("memory request changed while waiting for ready");

    a_flush_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dcache_flush_ack_o |=> !dcache_flush_ack_o)
        else $error("dcache_flush_ack_o high for two cycles");

    a_fetch_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_o |=> !fetch_valid_o)
        else $error("fetch_valid_o high for two cycles");

    a_dack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dack_o |=> !dack_o)
        else $error("dack_o high for two cycles");

endmodule

bind cache_subsystem cache_subsystem_chk cache_subsystem_chk_i (.*);

//--- cache_subsystem.sv
// L1 cache subsystem top level
`timescale 1ns/1ps

module cache_subsystem (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // instruction cache
    input  logic               icache_en_i,
    input  logic               icache_flush_i,
    input  logic               fetch_req_i,
    input  cache_pkg::addr_t   fetch_addr_i,
    output logic               fetch_valid_o,
    output cache_pkg::data_t   fetch_data_o,
    output logic               icache_miss_o,
    // data cache
    input  logic               dcache_enable_i,
    input  logic               dcache_flush_i,      // held until acknowledged
    output logic               dcache_flush_ack_o,
    input  logic               dreq_i,
    input  logic               dwe_i,
    input  cache_pkg::addr_t   daddr_i,
    input  cache_pkg::data_t   dwdata_i,
    output logic               dack_o,
    output cache_pkg::data_t   drdata_o,
    output logic               dcache_miss_o,
    // memory port
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic               mem_req_we_o,
    output cache_pkg::addr_t   mem_req_addr_o,
    output cache_pkg::data_t   mem_req_wdata_o,
    output cache_pkg::mem_id_t mem_req_id_o,
    input  logic               mem_rsp_valid_i,
    input  cache_pkg::mem_id_t mem_rsp_id_i,
    input  cache_pkg::data_t   mem_rsp_rdata_i
);

    logic             ic_req_valid;
    logic             ic_req_ready;
    cache_pkg::addr_t ic_req_addr;
    logic             ic_rsp_valid;

    logic             dc_req_valid;
    logic             dc_req_ready;
    logic             dc_req_we;
    cache_pkg::addr_t dc_req_addr;
    cache_pkg::data_t dc_req_wdata;
    logic             dc_rsp_valid;

    icache icache_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .en_i          (icache_en_i),
        .flush_i       (icache_flush_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .miss_o        (icache_miss_o),
        .req_valid_o   (ic_req_valid),
        .req_ready_i   (ic_req_ready),
        .req_addr_o    (ic_req_addr),
        .rsp_valid_i   (ic_rsp_valid),
        .rsp_rdata_i   (mem_rsp_rdata_i)    // data fans out to both caches
    );

    dcache dcache_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .enable_i    (dcache_enable_i),
        .flush_i     (dcache_flush_i),
        .flush_ack_o (dcache_flush_ack_o),
        .dreq_i      (dreq_i),
        .dwe_i       (dwe_i),
        .daddr_i     (daddr_i),
        .dwdata_i    (dwdata_i),
        .dack_o      (dack_o),
        .drdata_o    (drdata_o),
        .miss_o      (dcache_miss_o),
        .req_valid_o (dc_req_valid),
        .req_ready_i (dc_req_ready),
        .req_we_o    (dc_req_we),
        .req_addr_o  (dc_req_addr),
        .req_wdata_o (dc_req_wdata),
        .rsp_valid_i (dc_rsp_valid),
        .rsp_rdata_i (mem_rsp_rdata_i)
    );

    // ------------------------------------------------------------------------
    // shared memory port
    // ------------------------------------------------------------------------
    mem_port_arbiter mem_port_arbiter_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ic_req_valid_i  (ic_req_valid),
        .ic_req_addr_i   (ic_req_addr),
        .ic_req_ready_o  (ic_req_ready),
        .ic_rsp_valid_o  (ic_rsp_valid),
        .dc_req_valid_i  (dc_req_valid),
        .dc_req_we_i     (dc_req_we),
        .dc_req_addr_i   (dc_req_addr),
        .dc_req_wdata_i  (dc_req_wdata),
        .dc_req_ready_o  (dc_req_ready),
        .dc_rsp_valid_o  (dc_rsp_valid),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_we_o    (mem_req_we_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_req_wdata_o (mem_req_wdata_o),
        .mem_req_id_o    (mem_req_id_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_id_i    (mem_rsp_id_i)
    );

endmodule

//--- mem_port_arbiter.sv
// Round-robin memory port arbiter
`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // instruction cache side
    input  logic               ic_req_valid_i,
    input  cache_pkg::addr_t   ic_req_addr_i,
    output logic               ic_req_ready_o,
    output logic               ic_rsp_valid_o,
    // data cache side
    input  logic               dc_req_valid_i,
    input  logic               dc_req_we_i,
    input  cache_pkg::addr_t   dc_req_addr_i,
    input  cache_pkg::data_t   dc_req_wdata_i,
    output logic               dc_req_ready_o,
    output logic               dc_rsp_valid_o,
    // memory request out
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output logic               mem_req_we_o,
    output cache_pkg::addr_t   mem_req_addr_o,
    output cache_pkg::data_t   mem_req_wdata_o,
    output cache_pkg::mem_id_t mem_req_id_o,
    // memory response in
    input  logic               mem_rsp_valid_i,
    input  cache_pkg::mem_id_t mem_rsp_id_i
);

    cache_pkg::mem_id_t last_q;      // last accepted requester
    logic               locked_q;    // granted request still waiting for ready
    cache_pkg::mem_id_t lock_id_q;
    cache_pkg::mem_id_t grant;
    logic               dc_sel;

    always_comb begin
        if (locked_q) begin
            grant = lock_id_q;
        end else if (ic_req_valid_i && dc_req_valid_i) begin
            grant = (last_q == cache_pkg::ID_ICACHE) ? cache_pkg::ID_DCACHE
                                                     : cache_pkg::ID_ICACHE;
        end else if (dc_req_valid_i) begin
            grant = cache_pkg::ID_DCACHE;
        end else begin
            grant = cache_pkg::ID_ICACHE;
        end
    end

    assign dc_sel = (grant == cache_pkg::ID_DCACHE);

    // request mux
    assign mem_req_valid_o = dc_sel ? dc_req_valid_i : ic_req_valid_i;
    assign mem_req_we_o    = dc_sel && dc_req_we_i;   // icache only reads
    assign mem_req_addr_o  = dc_sel ? dc_req_addr_i : ic_req_addr_i;
    assign mem_req_wdata_o = dc_sel ? dc_req_wdata_i : '0;
    assign mem_req_id_o    = grant;
    assign ic_req_ready_o  = mem_req_ready_i && !dc_sel;
    assign dc_req_ready_o  = mem_req_ready_i && dc_sel;

    // response routing by id
    assign ic_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_id_i == cache_pkg::ID_ICACHE);
    assign dc_rsp_valid_o = mem_rsp_valid_i && (mem_rsp_id_i == cache_pkg::ID_DCACHE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_q    <= cache_pkg::ID_DCACHE;   // icache wins the first tie
            locked_q  <= 1'b0;
            lock_id_q <= cache_pkg::ID_ICACHE;
        end else if (mem_req_valid_o) begin
            if (mem_req_ready_i) begin
                last_q   <= grant;
                locked_q <= 1'b0;
            end else begin
                locked_q  <= 1'b1;
                lock_id_q <= grant;
            end
        end
    end

endmodule

//--- dcache.sv
// Write-through data cache
`timescale 1ns/1ps

module dcache (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             enable_i,
    input  logic             flush_i,
    output logic             flush_ack_o,
    input  logic             dreq_i,
    input  logic             dwe_i,
    input  cache_pkg::addr_t daddr_i,
    input  cache_pkg::data_t dwdata_i,
    output logic             dack_o,
    output cache_pkg::data_t drdata_o,
    output logic             miss_o,
    output logic             req_valid_o,
    input  logic             req_ready_i,
    output logic             req_we_o,
    output cache_pkg::addr_t req_addr_o,
    output cache_pkg::data_t req_wdata_o,
    input  logic             rsp_valid_i,
    input  cache_pkg::data_t rsp_rdata_i
);

    typedef enum logic [1:0] {
        IDLE,
        MEM_REQ,
        MEM_WAIT,
        FLUSH
    } state_e;

    state_e state_q;

    logic [cache_pkg::NUM_LINES-1:0] valid_q;
    cache_pkg::tag_t  tag_q  [cache_pkg::NUM_LINES];
    cache_pkg::data_t data_q [cache_pkg::NUM_LINES];

    logic             we_q;
    logic             fill_q;    // read miss with the cache enabled
    cache_pkg::addr_t addr_q;
    cache_pkg::data_t wdata_q;

    cache_pkg::index_t lookup_idx;
    cache_pkg::index_t fill_idx;
    logic              hit;
    logic              access_start;
    logic              rsp_done;

    assign lookup_idx   = cache_pkg::addr_index(daddr_i);
    assign fill_idx     = cache_pkg::addr_index(addr_q);
    assign hit          = enable_i && valid_q[lookup_idx]
                          && (tag_q[lookup_idx] == cache_pkg::addr_tag(daddr_i));
    assign access_start = (state_q == IDLE) && !flush_i && dreq_i;
    assign rsp_done     = (state_q == MEM_WAIT) && rsp_valid_i;

    assign req_valid_o = (state_q == MEM_REQ);
    assign req_we_o    = we_q;
    assign req_addr_o  = addr_q;
    assign req_wdata_o = wdata_q;

    // ------------------------------------------------------------------------
    // access and flush sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            valid_q     <= '0;
            we_q        <= 1'b0;
            fill_q      <= 1'b0;
            dack_o      <= 1'b0;
            miss_o      <= 1'b0;
            flush_ack_o <= 1'b0;
        end else begin
            dack_o      <= 1'b0;
            miss_o      <= 1'b0;
            flush_ack_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (flush_i) begin
                        valid_q     <= '0;   // invalidate right away
                        flush_ack_o <= 1'b1;
                        state_q     <= FLUSH;
                    end else if (dreq_i) begin
                        we_q   <= dwe_i;
                        fill_q <= !dwe_i && enable_i;
                        if (!dwe_i && hit) begin
                            dack_o <= 1'b1;
                        end else begin
                            miss_o  <= !dwe_i;   // only reads count as misses
                            state_q <= MEM_REQ;
                        end
                    end
                end
                MEM_REQ: if (req_ready_i) state_q <= MEM_WAIT;
                MEM_WAIT: begin
                    if (rsp_valid_i) begin
                        dack_o <= 1'b1;
                        if (fill_q) valid_q[fill_idx] <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                FLUSH: if (!flush_i) state_q <= IDLE;   // wait for the core to drop it
                default: state_q <= IDLE;
            endcase
        end
    end

    // arrays and payload
    always_ff @(posedge clk_i) begin
        if (access_start) begin
            addr_q   <= daddr_i;
            wdata_q  <= dwdata_i;
            drdata_o <= data_q[lookup_idx];
            if (dwe_i && hit) data_q[lookup_idx] <= dwdata_i;   // write hit updates line
        end
        if (rsp_done) begin
            drdata_o <= rsp_rdata_i;
            if (fill_q) begin
                tag_q[fill_idx]  <= cache_pkg::addr_tag(addr_q);
                data_q[fill_idx] <= rsp_rdata_i;
            end
        end
    end

endmodule

//--- icache.sv
// Direct-mapped instruction cache
`timescale 1ns/1ps

module icache (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             en_i,
    input  logic             flush_i,
    input  logic             fetch_req_i,
    input  cache_pkg::addr_t fetch_addr_i,
    output logic             fetch_valid_o,
    output cache_pkg::data_t fetch_data_o,
    output logic             miss_o,
    output logic             req_valid_o,
    input  logic             req_ready_i,
    output cache_pkg::addr_t req_addr_o,
    input  logic             rsp_valid_i,
    input  cache_pkg::data_t rsp_rdata_i
);

    typedef enum logic [1:0] {
        IDLE,
        MISS_REQ,
        MISS_WAIT
    } state_e;

    state_e state_q;

    logic [cache_pkg::NUM_LINES-1:0] valid_q;
    cache_pkg::tag_t  tag_q  [cache_pkg::NUM_LINES];
    cache_pkg::data_t data_q [cache_pkg::NUM_LINES];

    cache_pkg::addr_t addr_q;   // fetch in flight
    logic             fill_q;   // line gets refilled on response

    cache_pkg::index_t lookup_idx;
    cache_pkg::index_t fill_idx;
    logic              hit;
    logic              fetch_start;
    logic              rsp_done;

    assign lookup_idx  = cache_pkg::addr_index(fetch_addr_i);
    assign fill_idx    = cache_pkg::addr_index(addr_q);
    assign hit         = en_i && valid_q[lookup_idx]
                         && (tag_q[lookup_idx] == cache_pkg::addr_tag(fetch_addr_i));
    assign fetch_start = (state_q == IDLE) && fetch_req_i;
    assign rsp_done    = (state_q == MISS_WAIT) && rsp_valid_i;

    assign req_valid_o = (state_q == MISS_REQ);
    assign req_addr_o  = addr_q;

    // ------------------------------------------------------------------------
    // control path
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= IDLE;
            valid_q       <= '0;
            fill_q        <= 1'b0;
            fetch_valid_o <= 1'b0;
            miss_o        <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            miss_o        <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (fetch_req_i) begin
                        if (hit) begin
                            fetch_valid_o <= 1'b1;   // answered from the array
                        end else begin
                            miss_o  <= 1'b1;
                            fill_q  <= en_i;         // bypass never fills
                            state_q <= MISS_REQ;
                        end
                    end
                end
                MISS_REQ: if (req_ready_i) state_q <= MISS_WAIT;
                MISS_WAIT: begin
                    if (rsp_valid_i) begin
                        fetch_valid_o <= 1'b1;
                        if (fill_q) valid_q[fill_idx] <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
            if (flush_i) valid_q <= '0;   // wins over a refill in the same cycle
        end
    end

    // arrays and payload
    always_ff @(posedge clk_i) begin
        if (fetch_start) begin
            addr_q       <= fetch_addr_i;
            fetch_data_o <= data_q[lookup_idx];
        end
        if (rsp_done) begin
            fetch_data_o <= rsp_rdata_i;
            if (fill_q) begin
                tag_q[fill_idx]  <= cache_pkg::addr_tag(addr_q);
                data_q[fill_idx] <= rsp_rdata_i;
            end
        end
    end

endmodule

//--- cache_pkg.sv
// Cache subsystem shared definitions

package cache_pkg;

    // ------------------------------------------------------------------------
    // widths and geometry
    // ------------------------------------------------------------------------
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int NUM_LINES = 4;
    localparam int INDEX_W   = $clog2(NUM_LINES);
    localparam int INDEX_LSB = 2;                     // word aligned accesses
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
    localparam int TAG_W     = ADDR_W - TAG_LSB;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // memory transaction ids
    typedef logic [0:0] mem_id_t;
    localparam mem_id_t ID_ICACHE = 1'b0;
    localparam mem_id_t ID_DCACHE = 1'b1;

    // address field extraction
    function automatic index_t addr_index(addr_t addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

endpackage
